/* hdl/soc_pkg.sv */
`default_nettype none

package soc_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [7:0]  byte_t;

    typedef enum logic [1:0] {
        TGT_RAM   = 2'd0,
        TGT_UART  = 2'd1,
        TGT_CLINT = 2'd2,
        TGT_NONE  = 2'd3
    } target_e;

    // **************************************************
    // address map, limits are inclusive.
    // **************************************************
    localparam addr_t RAM_BASE    = 32'h0000_0000;
    localparam addr_t RAM_LIMIT   = 32'h0000_0FFF;
    localparam addr_t CLINT_BASE  = 32'h0200_0000;
    localparam addr_t CLINT_LIMIT = 32'h0200_00FF;
    localparam addr_t UART_BASE   = 32'h1000_0000;
    localparam addr_t UART_LIMIT  = 32'h1000_00FF;

    localparam addr_t UART_TX_OFS   = 32'h0;
    localparam addr_t UART_RX_OFS   = 32'h4;
    localparam addr_t UART_STAT_OFS = 32'h8;

    localparam addr_t CLINT_MTIME_OFS    = 32'h0;
    localparam addr_t CLINT_MTIMECMP_OFS = 32'h4;

    // merges the strobed bytes of new_word into old_word.
    function automatic data_t apply_strb(data_t old_word, data_t new_word, strb_t strb);
        data_t merged;
        merged = old_word;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) begin
                merged[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return merged;
    endfunction

endpackage

`default_nettype wire

/* hdl/mem_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface mem_bus_if;
    import soc_pkg::*;

    // request channel, req_addr is already relative to the target window.
    logic  req_valid;
    logic  req_ready;
    addr_t req_addr;
    logic  req_write;
    data_t req_wdata;
    strb_t req_strb;

    // response channel.
    logic  rsp_valid;
    logic  rsp_ready;
    data_t rsp_rdata;

    modport master (
        output req_valid, req_addr, req_write, req_wdata, req_strb, rsp_ready,
        input  req_ready, rsp_valid, rsp_rdata
    );

    modport slave (
        input  req_valid, req_addr, req_write, req_wdata, req_strb, rsp_ready,
        output req_ready, rsp_valid, rsp_rdata
    );

endinterface

`default_nettype wire

/* hdl/rst_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module rst_sync #(
    parameter int STAGES = 2
) (
    input  wire  clock,
    input  wire  rst_n_i,
    output logic rst_n_o
);

    logic [STAGES-1:0] sync_q;

    // assertion is immediate, release ripples through STAGES flops.
    always_ff @(posedge clock or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sync_q <= '0;
        end else begin
            sync_q <= STAGES'({sync_q, 1'b1});
        end
    end

    assign rst_n_o = sync_q[STAGES-1];

endmodule

`default_nettype wire

/* hdl/bus_xbar.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_xbar (
    input  wire                 clock,
    input  wire                 rst_n_i,
    input  wire                 req_valid_i,
    output logic                req_ready_o,
    input  wire soc_pkg::addr_t req_addr_i,
    input  wire                 req_write_i,
    input  wire soc_pkg::data_t req_wdata_i,
    input  wire soc_pkg::strb_t req_strb_i,
    output logic                rsp_valid_o,
    input  wire                 rsp_ready_i,
    output soc_pkg::data_t      rsp_rdata_o,
    output logic                rsp_err_o,
    mem_bus_if.master           tgt_ram,
    mem_bus_if.master           tgt_uart,
    mem_bus_if.master           tgt_clint
);
    import soc_pkg::*;

    typedef enum logic [1:0] {IDLE, ISSUE, WAIT_RSP, RESPOND} state_e;

    state_e  state_q;
    state_e  state_d;
    target_e dec_sel;
    target_e sel_q;
    addr_t   dec_ofs;
    addr_t   addr_q;
    logic    write_q;
    data_t   wdata_q;
    strb_t   strb_q;
    data_t   rdata_q;
    logic    err_q;
    logic    accept;
    logic    tgt_req_ready;
    logic    tgt_rsp_valid;
    data_t   tgt_rsp_rdata;

    // **************************************************
    // address decode
    // **************************************************
    always_comb begin
        dec_sel = TGT_NONE;
        dec_ofs = req_addr_i;
        if (req_addr_i >= RAM_BASE && req_addr_i <= RAM_LIMIT) begin
            dec_sel = TGT_RAM;
            dec_ofs = req_addr_i - RAM_BASE;
        end else if (req_addr_i >= UART_BASE && req_addr_i <= UART_LIMIT) begin
            dec_sel = TGT_UART;
            dec_ofs = req_addr_i - UART_BASE;
        end else if (req_addr_i >= CLINT_BASE && req_addr_i <= CLINT_LIMIT) begin
            dec_sel = TGT_CLINT;
            dec_ofs = req_addr_i - CLINT_BASE;
        end
    end

    assign req_ready_o = (state_q == IDLE);
    assign accept      = req_valid_i && req_ready_o;

    // handshake signals of the selected target.
    always_comb begin
        case (sel_q)
            TGT_RAM: begin
                tgt_req_ready = tgt_ram.req_ready;
                tgt_rsp_valid = tgt_ram.rsp_valid;
                tgt_rsp_rdata = tgt_ram.rsp_rdata;
            end
            TGT_UART: begin
                tgt_req_ready = tgt_uart.req_ready;
                tgt_rsp_valid = tgt_uart.rsp_valid;
                tgt_rsp_rdata = tgt_uart.rsp_rdata;
            end
            TGT_CLINT: begin
                tgt_req_ready = tgt_clint.req_ready;
                tgt_rsp_valid = tgt_clint.rsp_valid;
                tgt_rsp_rdata = tgt_clint.rsp_rdata;
            end
            default: begin
                tgt_req_ready = 1'b0;
                tgt_rsp_valid = 1'b0;
                tgt_rsp_rdata = '0;
            end
        endcase
    end

    // **************************************************
    // transaction FSM
    // **************************************************
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (accept) begin
                    state_d = (dec_sel == TGT_NONE) ? RESPOND : ISSUE;
                end
            end
            ISSUE: begin
                if (tgt_req_ready) state_d = WAIT_RSP;
            end
            WAIT_RSP: begin
                if (tgt_rsp_valid) state_d = RESPOND;
            end
            RESPOND: begin
                if (rsp_ready_i) state_d = IDLE;
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            sel_q   <= TGT_NONE;
            err_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            if (accept) begin
                sel_q <= dec_sel;
                err_q <= (dec_sel == TGT_NONE); // unmapped address.
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            addr_q  <= dec_ofs;
            write_q <= req_write_i;
            wdata_q <= req_wdata_i;
            strb_q  <= req_strb_i;
            rdata_q <= '0; // an error response returns zero.
        end else if (state_q == WAIT_RSP && tgt_rsp_valid) begin
            rdata_q <= tgt_rsp_rdata;
        end
    end

    assign rsp_valid_o = (state_q == RESPOND);
    assign rsp_rdata_o = rdata_q;
    assign rsp_err_o   = err_q;

    // **************************************************
    // target request fan-out
    // **************************************************
    assign tgt_ram.req_valid   = (state_q == ISSUE) && (sel_q == TGT_RAM);
    assign tgt_ram.req_addr    = addr_q;
    assign tgt_ram.req_write   = write_q;
    assign tgt_ram.req_wdata   = wdata_q;
    assign tgt_ram.req_strb    = strb_q;
    assign tgt_ram.rsp_ready   = (state_q == WAIT_RSP) && (sel_q == TGT_RAM);

    assign tgt_uart.req_valid  = (state_q == ISSUE) && (sel_q == TGT_UART);
    assign tgt_uart.req_addr   = addr_q;
    assign tgt_uart.req_write  = write_q;
    assign tgt_uart.req_wdata  = wdata_q;
    assign tgt_uart.req_strb   = strb_q;
    assign tgt_uart.rsp_ready  = (state_q == WAIT_RSP) && (sel_q == TGT_UART);

    assign tgt_clint.req_valid = (state_q == ISSUE) && (sel_q == TGT_CLINT);
    assign tgt_clint.req_addr  = addr_q;
    assign tgt_clint.req_write = write_q;
    assign tgt_clint.req_wdata = wdata_q;
    assign tgt_clint.req_strb  = strb_q;
    assign tgt_clint.rsp_ready = (state_q == WAIT_RSP) && (sel_q == TGT_CLINT);

endmodule

`default_nettype wire

/* hdl/sim_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module sim_ram #(
    parameter int WORDS = 1024
) (
    input  wire      clock,
    input  wire      rst_n_i,
    mem_bus_if.slave bus
);
    import soc_pkg::*;

    localparam int IDX_W = (WORDS > 1) ? $clog2(WORDS) : 1;

    data_t            mem [WORDS];
    logic [IDX_W-1:0] word_idx;
    logic             req_fire;

    // byte offset to word index, wrapping at WORDS.
    assign word_idx = IDX_W'((bus.req_addr >> 2) % WORDS);

    assign bus.req_ready = !bus.rsp_valid; // one response in flight at most.
    assign req_fire      = bus.req_valid && bus.req_ready;

    always_ff @(posedge clock or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bus.rsp_valid <= 1'b0;
        end else if (req_fire) begin
            bus.rsp_valid <= 1'b1;
        end else if (bus.rsp_ready) begin
            bus.rsp_valid <= 1'b0;
        end
    end

    // **************************************************
    // storage
    // **************************************************
    always_ff @(posedge clock) begin
        if (req_fire) begin
            if (bus.req_write) begin
                mem[word_idx] <= apply_strb(mem[word_idx], bus.req_wdata, bus.req_strb);
                bus.rsp_rdata <= '0;
            end else begin
                bus.rsp_rdata <= mem[word_idx];
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/uart_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_regs (
    input  wire                 clock,
    input  wire                 rst_n_i,
    mem_bus_if.slave            bus,
    output logic                uart_tx_valid_o,
    output soc_pkg::byte_t      uart_tx_ch_o,
    input  wire                 uart_rx_valid_i,
    input  wire soc_pkg::byte_t uart_rx_ch_i
);
    import soc_pkg::*;

    logic  req_fire;
    logic  tx_write;
    logic  rx_read;
    logic  rx_full;
    byte_t rx_hold;

    assign bus.req_ready = !bus.rsp_valid;
    assign req_fire      = bus.req_valid && bus.req_ready;
    assign tx_write      = req_fire && bus.req_write && (bus.req_addr == UART_TX_OFS);
    assign rx_read       = req_fire && !bus.req_write && (bus.req_addr == UART_RX_OFS);

    // **************************************************
    // control state
    // **************************************************
    always_ff @(posedge clock or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bus.rsp_valid   <= 1'b0;
            uart_tx_valid_o <= 1'b0;
            rx_full         <= 1'b0;
        end else begin
            uart_tx_valid_o <= tx_write; // single cycle pulse per write.
            if (req_fire) begin
                bus.rsp_valid <= 1'b1;
            end else if (bus.rsp_ready) begin
                bus.rsp_valid <= 1'b0;
            end
            // a new character wins over a read in the same cycle.
            if (uart_rx_valid_i) begin
                rx_full <= 1'b1;
            end else if (rx_read) begin
                rx_full <= 1'b0;
            end
        end
    end

    // **************************************************
    // data path
    // **************************************************
    always_ff @(posedge clock) begin
        if (tx_write) begin
            uart_tx_ch_o <= bus.req_wdata[7:0];
        end
        if (uart_rx_valid_i) begin
            rx_hold <= uart_rx_ch_i;
        end
        if (req_fire) begin
            bus.rsp_rdata <= '0;
            if (!bus.req_write) begin
                case (bus.req_addr)
                    UART_RX_OFS:   bus.rsp_rdata <= data_t'(rx_hold);
                    UART_STAT_OFS: bus.rsp_rdata <= data_t'(rx_full);
                    default:       bus.rsp_rdata <= '0;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/clint_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module clint_timer (
    input  wire      clock,
    input  wire      rst_n_i,
    mem_bus_if.slave bus,
    output logic     timer_irq_o
);
    import soc_pkg::*;

    data_t mtime;
    data_t mtimecmp;
    logic  req_fire;
    logic  wr_mtime;
    logic  wr_cmp;

    assign bus.req_ready = !bus.rsp_valid;
    assign req_fire      = bus.req_valid && bus.req_ready;
    assign wr_mtime      = req_fire && bus.req_write && (bus.req_addr == CLINT_MTIME_OFS);
    assign wr_cmp        = req_fire && bus.req_write && (bus.req_addr == CLINT_MTIMECMP_OFS);

    // **************************************************
    // timer registers
    // **************************************************
    always_ff @(posedge clock or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mtime       <= '0;
            mtimecmp    <= '1; // keeps the interrupt off until programmed.
            timer_irq_o <= 1'b0;
        end else begin
            if (wr_mtime) begin
                mtime <= apply_strb(mtime, bus.req_wdata, bus.req_strb);
            end else begin
                mtime <= mtime + 1'b1;
            end
            if (wr_cmp) begin
                mtimecmp <= apply_strb(mtimecmp, bus.req_wdata, bus.req_strb);
            end
            timer_irq_o <= (mtime >= mtimecmp);
        end
    end

    always_ff @(posedge clock or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bus.rsp_valid <= 1'b0;
        end else if (req_fire) begin
            bus.rsp_valid <= 1'b1;
        end else if (bus.rsp_ready) begin
            bus.rsp_valid <= 1'b0;
        end
    end

    // read data is sampled when the request is taken.
    always_ff @(posedge clock) begin
        if (req_fire) begin
            if (bus.req_write) begin
                bus.rsp_rdata <= '0;
            end else begin
                case (bus.req_addr)
                    CLINT_MTIME_OFS:    bus.rsp_rdata <= mtime;
                    CLINT_MTIMECMP_OFS: bus.rsp_rdata <= mtimecmp;
                    default:            bus.rsp_rdata <= '0;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/soc_top.sv */
`timescale 1ns/1ps
`default_nettype none

module soc_top #(
    parameter int RAM_WORDS  = 1024,
    parameter int RST_STAGES = 2
) (
    input  wire                 clock,
    input  wire                 rst_n_i,
    input  wire                 req_valid_i,
    output logic                req_ready_o,
    input  wire soc_pkg::addr_t req_addr_i,
    input  wire                 req_write_i,
    input  wire soc_pkg::data_t req_wdata_i,
    input  wire soc_pkg::strb_t req_strb_i,
    output logic                rsp_valid_o,
    input  wire                 rsp_ready_i,
    output soc_pkg::data_t      rsp_rdata_o,
    output logic                rsp_err_o,
    output logic                uart_tx_valid_o,
    output soc_pkg::byte_t      uart_tx_ch_o,
    input  wire                 uart_rx_valid_i,
    input  wire soc_pkg::byte_t uart_rx_ch_i,
    output logic                timer_irq_o
);
    import soc_pkg::*;

    logic rst_core_n;
    logic rst_peri_n;

    // one bus per target, indexed by target_e.
    mem_bus_if bus_if [3] ();

    // **************************************************
    // reset domains
    // **************************************************
    rst_sync #(.STAGES(RST_STAGES)) u_rst_core (
        .clock   (clock),
        .rst_n_i (rst_n_i),
        .rst_n_o (rst_core_n)
    );

    rst_sync #(.STAGES(RST_STAGES)) u_rst_peri (
        .clock   (clock),
        .rst_n_i (rst_n_i),
        .rst_n_o (rst_peri_n)
    );

    // **************************************************
    // fabric
    // **************************************************
    bus_xbar u_xbar (
        .clock       (clock),
        .rst_n_i     (rst_core_n),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .req_addr_i  (req_addr_i),
        .req_write_i (req_write_i),
        .req_wdata_i (req_wdata_i),
        .req_strb_i  (req_strb_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .rsp_rdata_o (rsp_rdata_o),
        .rsp_err_o   (rsp_err_o),
        .tgt_ram     (bus_if[TGT_RAM].master),
        .tgt_uart    (bus_if[TGT_UART].master),
        .tgt_clint   (bus_if[TGT_CLINT].master)
    );

    sim_ram #(.WORDS(RAM_WORDS)) u_ram (
        .clock   (clock),
        .rst_n_i (rst_core_n),
        .bus     (bus_if[TGT_RAM].slave)
    );

    // peripherals sit in their own reset domain.
    uart_regs u_uart (
        .clock           (clock),
        .rst_n_i         (rst_peri_n),
        .bus             (bus_if[TGT_UART].slave),
        .uart_tx_valid_o (uart_tx_valid_o),
        .uart_tx_ch_o    (uart_tx_ch_o),
        .uart_rx_valid_i (uart_rx_valid_i),
        .uart_rx_ch_i    (uart_rx_ch_i)
    );

    clint_timer u_clint (
        .clock       (clock),
        .rst_n_i     (rst_peri_n),
        .bus         (bus_if[TGT_CLINT].slave),
        .timer_irq_o (timer_irq_o)
    );

endmodule

`default_nettype wire

/* tests/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter real PERIOD_NS = 4.0
) (
    output logic clock_o
);

    // free-running clock, first rising edge at half a period.
    initial begin
        clock_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) clock_o = ~clock_o;
        end
    end

endmodule

`default_nettype wire

/* tests/soc_top_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module soc_top_tb;
    import soc_pkg::*;

    localparam int RST_CYCLES  = 16;
    localparam int RST_STAGES  = 2;
    localparam int MAX_ENTRIES = 32;

    // entry modes select the extra check done besides rdata and err.
    localparam int M_DATA    = 0;
    localparam int M_MTIME   = 1;
    localparam int M_IRQ_HI  = 2;
    localparam int M_IRQ_LO  = 3;
    localparam int M_RX      = 4;
    localparam int M_TX      = 5;

    logic  clock;
    logic  rst_n_i;
    logic  req_valid_i;
    logic  req_ready_o;
    addr_t req_addr_i;
    logic  req_write_i;
    data_t req_wdata_i;
    strb_t req_strb_i;
    logic  rsp_valid_o;
    logic  rsp_ready_i;
    data_t rsp_rdata_o;
    logic  rsp_err_o;
    logic  uart_tx_valid_o;
    byte_t uart_tx_ch_o;
    logic  uart_rx_valid_i;
    byte_t uart_rx_ch_i;
    logic  timer_irq_o;

    int    tbl_mode  [MAX_ENTRIES];
    logic  tbl_wr    [MAX_ENTRIES];
    addr_t tbl_addr  [MAX_ENTRIES];
    data_t tbl_wdata [MAX_ENTRIES];
    strb_t tbl_strb  [MAX_ENTRIES];
    data_t tbl_rdata [MAX_ENTRIES];
    logic  tbl_err   [MAX_ENTRIES];
    int    n_entries   = 0;

    integer seed        = 32'h4c00;
    int     cycle_count = 0;
    int     rsp_count   = 0;
    int     tx_count    = 0;
    byte_t  tx_last;
    logic   rx_pending;
    byte_t  rx_char;
    data_t  last_mtime  = '0;

    tb_clock_gen #(.PERIOD_NS(4.0)) u_clock_gen (.clock_o(clock));

    soc_top #(.RAM_WORDS(1024), .RST_STAGES(RST_STAGES)) DUT (
        .clock(clock), .rst_n_i(rst_n_i),
        .req_valid_i(req_valid_i), .req_ready_o(req_ready_o), .req_addr_i(req_addr_i),
        .req_write_i(req_write_i), .req_wdata_i(req_wdata_i), .req_strb_i(req_strb_i),
        .rsp_valid_o(rsp_valid_o), .rsp_ready_i(rsp_ready_i), .rsp_rdata_o(rsp_rdata_o),
        .rsp_err_o(rsp_err_o), .uart_tx_valid_o(uart_tx_valid_o), .uart_tx_ch_o(uart_tx_ch_o),
        .uart_rx_valid_i(uart_rx_valid_i), .uart_rx_ch_i(uart_rx_ch_i),
        .timer_irq_o(timer_irq_o)
    );

    // strobed lanes take the new data and the others keep the old word.
    function automatic data_t merge_bytes(data_t old_word, data_t new_word, strb_t strb);
        data_t mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    task automatic check_value(input string name, input data_t actual, input data_t expected);
        if (actual !== expected) begin
            $display("[ERROR] time %0t %s: got 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
            $display("Result: FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic add_entry(input int mode, input logic wr, input addr_t addr,
                             input data_t wdata, input strb_t strb,
                             input data_t exp_rdata, input logic exp_err);
        tbl_mode[n_entries]  = mode;
        tbl_wr[n_entries]    = wr;
        tbl_addr[n_entries]  = addr;
        tbl_wdata[n_entries] = wdata;
        tbl_strb[n_entries]  = strb;
        tbl_rdata[n_entries] = exp_rdata;
        tbl_err[n_entries]   = exp_err;
        n_entries++;
    endtask

    // **************************************************
    // stimulus table
    // **************************************************
    task automatic fill_table();
        add_entry(M_DATA, 1'b1, RAM_BASE + 32'h000, 32'hDEAD_BEEF, 4'hF, 32'h0, 1'b0);
        add_entry(M_DATA, 1'b1, RAM_BASE + 32'h004, 32'h0123_4567, 4'hF, 32'h0, 1'b0);
        add_entry(M_DATA, 1'b1, RAM_BASE + 32'hFFC, 32'hCAFE_F00D, 4'hF, 32'h0, 1'b0);
        add_entry(M_DATA, 1'b0, RAM_BASE + 32'h000, 32'h0, 4'hF, 32'hDEAD_BEEF, 1'b0);
        add_entry(M_DATA, 1'b0, RAM_BASE + 32'h004, 32'h0, 4'hF, 32'h0123_4567, 1'b0);
        add_entry(M_DATA, 1'b0, RAM_BASE + 32'hFFC, 32'h0, 4'hF, 32'hCAFE_F00D, 1'b0);
        add_entry(M_DATA, 1'b1, RAM_BASE + 32'h010, 32'h1122_3344, 4'hF, 32'h0, 1'b0);
        add_entry(M_DATA, 1'b1, RAM_BASE + 32'h010, 32'hAABB_CCDD, 4'b0101, 32'h0, 1'b0);
        add_entry(M_DATA, 1'b0, RAM_BASE + 32'h010, 32'h0, 4'hF,
                  merge_bytes(32'h1122_3344, 32'hAABB_CCDD, 4'b0101), 1'b0);
        add_entry(M_DATA, 1'b1, RAM_BASE + 32'h014, 32'h5566_7788, 4'hF, 32'h0, 1'b0);
        add_entry(M_DATA, 1'b1, RAM_BASE + 32'h014, 32'h99AA_BBCC, 4'b1010, 32'h0, 1'b0);
        add_entry(M_DATA, 1'b0, RAM_BASE + 32'h014, 32'h0, 4'hF,
                  merge_bytes(32'h5566_7788, 32'h99AA_BBCC, 4'b1010), 1'b0);
        add_entry(M_DATA, 1'b0, 32'h2000_0000, 32'h0, 4'hF, 32'h0, 1'b1); // unmapped.
        add_entry(M_DATA, 1'b1, RAM_LIMIT + 1, 32'hFFFF_FFFF, 4'hF, 32'h0, 1'b1);
        add_entry(M_DATA, 1'b0, RAM_BASE + 32'h000, 32'h0, 4'hF, 32'hDEAD_BEEF, 1'b0);
        add_entry(M_TX, 1'b1, UART_BASE + UART_TX_OFS, 32'h0000_1241, 4'hF, 32'h0, 1'b0);
        add_entry(M_TX, 1'b1, UART_BASE + UART_TX_OFS, 32'h0000_005A, 4'hF, 32'h0, 1'b0);
        // for receive entries the wdata column is the character pulsed in first.
        add_entry(M_RX, 1'b0, UART_BASE + UART_STAT_OFS, 32'h0000_00C3, 4'hF, 32'h1, 1'b0);
        add_entry(M_DATA, 1'b0, UART_BASE + UART_RX_OFS, 32'h0, 4'hF, 32'h0000_00C3, 1'b0);
        add_entry(M_DATA, 1'b0, UART_BASE + UART_STAT_OFS, 32'h0, 4'hF, 32'h0, 1'b0);
        add_entry(M_MTIME, 1'b0, CLINT_BASE + CLINT_MTIME_OFS, 32'h0, 4'hF, 32'h0, 1'b0);
        add_entry(M_MTIME, 1'b0, CLINT_BASE + CLINT_MTIME_OFS, 32'h0, 4'hF, 32'h0, 1'b0);
        add_entry(M_IRQ_LO, 1'b0, CLINT_BASE + CLINT_MTIMECMP_OFS, 32'h0, 4'hF, '1, 1'b0);
        add_entry(M_IRQ_HI, 1'b1, CLINT_BASE + CLINT_MTIMECMP_OFS, 32'h0, 4'hF, 32'h0, 1'b0);
        add_entry(M_IRQ_LO, 1'b1, CLINT_BASE + CLINT_MTIMECMP_OFS, '1, 4'hF, 32'h0, 1'b0);
        add_entry(M_DATA, 1'b0, RAM_BASE + 32'h004, 32'h0, 4'hF, 32'h0123_4567, 1'b0);
    endtask

    // called on a rising edge and returns on the edge of the response transfer.
    task automatic run_entry(input int idx);
        int tx_before;
        if (tbl_mode[idx] == M_RX) begin
            rx_char    <= tbl_wdata[idx][7:0];
            rx_pending <= 1'b1;
            @(posedge clock);
            while (rx_pending) @(posedge clock);
        end
        tx_before    = tx_count;
        req_valid_i <= 1'b1;
        req_addr_i  <= tbl_addr[idx];
        req_write_i <= tbl_wr[idx];
        req_wdata_i <= tbl_wdata[idx];
        req_strb_i  <= tbl_strb[idx];
        @(posedge clock);
        while (!req_ready_o) @(posedge clock);
        req_valid_i <= 1'b0;
        @(posedge clock);
        // only one request may be in flight until its response is taken.
        check_value("req_ready_o", data_t'(req_ready_o), 32'd0);
        while (!(rsp_valid_o && rsp_ready_i)) begin
            @(posedge clock);
            check_value("req_ready_o", data_t'(req_ready_o), 32'd0);
        end
        if (tbl_mode[idx] == M_MTIME) begin
            check_value("mtime increase", data_t'(rsp_rdata_o > last_mtime), 32'd1);
            last_mtime = rsp_rdata_o;
        end else begin
            check_value("rsp_rdata_o", rsp_rdata_o, tbl_rdata[idx]);
        end
        check_value("rsp_err_o", data_t'(rsp_err_o), data_t'(tbl_err[idx]));
        if (tbl_mode[idx] == M_TX) begin
            check_value("uart_tx_valid_o pulses", data_t'(tx_count - tx_before), 32'd1);
            check_value("uart_tx_ch_o", data_t'(tx_last), data_t'(tbl_wdata[idx][7:0]));
        end
        if (tbl_mode[idx] == M_IRQ_HI || tbl_mode[idx] == M_IRQ_LO) begin
            check_value("timer_irq_o", data_t'(timer_irq_o), data_t'(tbl_mode[idx] == M_IRQ_HI));
        end
    endtask

    // **************************************************
    // side processes
    // **************************************************
    always @(posedge clock) begin
        rsp_ready_i <= ($random(seed) & 3) != 0; // low about one cycle in four.
        if (rsp_valid_o && rsp_ready_i) rsp_count <= rsp_count + 1;
        if (uart_tx_valid_o) begin
            tx_count <= tx_count + 1;
            tx_last  <= uart_tx_ch_o;
        end
    end

    // receive pulse of one cycle per request from the table loop.
    always @(posedge clock) begin
        if (uart_rx_valid_i) begin
            uart_rx_valid_i <= 1'b0;
            rx_pending      <= 1'b0;
        end else if (rx_pending) begin
            uart_rx_valid_i <= 1'b1;
            uart_rx_ch_i    <= rx_char;
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > RST_CYCLES + RST_STAGES + 4 + 64 * n_entries) begin
            $display("timeout: the table did not finish after %0d cycles", cycle_count);
            $display("Result: FAILED");
            $fatal(1, "simulation timed out");
        end
    end

    initial begin
        rst_n_i         = 1'b0;
        req_valid_i     = 1'b0;
        req_addr_i      = '0;
        req_write_i     = 1'b0;
        req_wdata_i     = '0;
        req_strb_i      = '0;
        rsp_ready_i     = 1'b0;
        uart_rx_valid_i = 1'b0;
        uart_rx_ch_i    = '0;
        rx_pending      = 1'b0;
        rx_char         = '0;
        fill_table();
        repeat (RST_CYCLES) @(posedge clock);
        rst_n_i <= 1'b1;
        repeat (RST_STAGES + 2) @(posedge clock); // both synchronizers released.
        check_value("req_ready_o", data_t'(req_ready_o), 32'd1);
        check_value("rsp_valid_o", data_t'(rsp_valid_o), 32'd0);
        check_value("uart_tx_valid_o", data_t'(uart_tx_valid_o), 32'd0);
        check_value("timer_irq_o", data_t'(timer_irq_o), 32'd0);
        for (int i = 0; i < n_entries; i++) begin
            run_entry(i);
        end
        @(posedge clock);
        if (rsp_count == n_entries) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("transfer count wrong: %0d responses for %0d entries",
                     rsp_count, n_entries);
            $display("Result: FAILED");
            $fatal(1, "lost or repeated transfer");
        end
    end

endmodule

`default_nettype wire

/* compile.f */
hdl/soc_pkg.sv
hdl/mem_bus_if.sv
hdl/rst_sync.sv
hdl/bus_xbar.sv
hdl/sim_ram.sv
hdl/uart_regs.sv
hdl/clint_timer.sv
hdl/soc_top.sv
tests/tb_clock_gen.sv
tests/soc_top_tb.sv
